/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths
`define DATA_W    16
`define INSTR_W   32
`define HALF_W    16
`define ADDR_W    16
`define REG_NUM   8
`define REG_SEL_W 3
`define FLAG_W    4

// flag bit positions
`define FLAG_C 0
`define FLAG_S 1
`define FLAG_O 2
`define FLAG_Z 3

// opcodes with 13 and 14 left as no-ops
`define OP_ADD   4'd0
`define OP_SUB   4'd1
`define OP_AND   4'd2
`define OP_OR    4'd3
`define OP_XOR   4'd4
`define OP_CMP   4'd5
`define OP_MOV   4'd6
`define OP_MOVL  4'd7
`define OP_MOVH  4'd8
`define OP_JMP   4'd9
`define OP_LOAD  4'd10
`define OP_STORE 4'd11
`define OP_MOVF  4'd12
`define OP_HALT  4'd15

// condition codes
`define COND_AL 2'd0
`define COND_EQ 2'd1
`define COND_NE 2'd2
`define COND_CS 2'd3

`endif

/* core_pkg.sv */
`include "core_params.svh"

package core_pkg;

	// data and instruction words
	typedef logic [`DATA_W-1:0]  data_t;
	typedef logic [`INSTR_W-1:0] instr_t;
	typedef logic [`HALF_W-1:0]  half_t;
	typedef logic [`ADDR_W-1:0]  addr_t;

	// register code and flag register
	typedef logic [`REG_SEL_W-1:0] reg_sel_t;
	typedef logic [`FLAG_W-1:0]    flags_t;

	// instruction fields
	typedef logic [3:0] opcode_t;
	typedef logic [7:0] imm_t;

	// machine cycle steps with the memory steps between execute and save
	typedef enum logic [2:0] {
		STEP_IDLE,
		STEP_FETCH,
		STEP_DECODE,
		STEP_EXECUTE,
		STEP_SAVE,
		STEP_MEM_REQ,
		STEP_MEM_REL
	} step_t;

endpackage

/* instr_decoder.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module instr_decoder import core_pkg::*; (
	input  half_t    instr,
	input  flags_t   flags,
	output opcode_t  opcode,
	output reg_sel_t rd,
	output reg_sel_t rs,
	output imm_t     imm,
	output logic     cond_pass,
	output logic     alu_en,
	output logic     mov_en,
	output logic     movl_en,
	output logic     movh_en,
	output logic     movf_en,
	output logic     jump_en,
	output logic     load_en,
	output logic     store_en,
	output logic     halt_en
);

	logic [1:0] cond;
	logic       cond_hold;

	// field slicing
	assign opcode = instr[15:12];
	assign rd     = instr[11:9];
	assign rs     = instr[8:6];
	assign imm    = instr[8:1];
	assign cond   = instr[5:4];

	// condition verdict against current flags
	always_comb begin
		case (cond)
			`COND_EQ: cond_hold = flags[`FLAG_Z];
			`COND_NE: cond_hold = !flags[`FLAG_Z];
			`COND_CS: cond_hold = flags[`FLAG_C];
			default:  cond_hold = 1'b1;
		endcase
	end

	// immediate forms have no condition field
	assign cond_pass = movl_en || movh_en || cond_hold;

	// one class enable per opcode
	always_comb begin
		alu_en   = 1'b0;
		mov_en   = 1'b0;
		movl_en  = 1'b0;
		movh_en  = 1'b0;
		movf_en  = 1'b0;
		jump_en  = 1'b0;
		load_en  = 1'b0;
		store_en = 1'b0;
		halt_en  = 1'b0;
		case (opcode)
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR, `OP_CMP: alu_en = 1'b1;
			`OP_MOV:   mov_en   = 1'b1;
			`OP_MOVL:  movl_en  = 1'b1;
			`OP_MOVH:  movh_en  = 1'b1;
			`OP_MOVF:  movf_en  = 1'b1;
			`OP_JMP:   jump_en  = 1'b1;
			`OP_LOAD:  load_en  = 1'b1;
			`OP_STORE: store_en = 1'b1;
			`OP_HALT:  halt_en  = 1'b1;
			default: ;
		endcase
	end

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module alu import core_pkg::*; (
	input  opcode_t opcode,
	input  data_t   op_a,
	input  data_t   op_b,
	output data_t   result,
	output flags_t  flags_out
);

	localparam int MSB = `DATA_W - 1;

	logic carry;
	logic ovf;

	always_comb begin
		carry  = 1'b0;
		ovf    = 1'b0;
		result = op_a;
		case (opcode)
			`OP_ADD: begin
				{carry, result} = {1'b0, op_a} + {1'b0, op_b};
				ovf = (op_a[MSB] == op_b[MSB]) && (result[MSB] != op_a[MSB]);
			end
			// carry is the borrow here
			`OP_SUB, `OP_CMP: begin
				{carry, result} = {1'b0, op_a} - {1'b0, op_b};
				ovf = (op_a[MSB] != op_b[MSB]) && (result[MSB] != op_a[MSB]);
			end
			`OP_AND: result = op_a & op_b;
			`OP_OR:  result = op_a | op_b;
			`OP_XOR: result = op_a ^ op_b;
			default: result = op_a;
		endcase
	end

	// sign and zero come from the result for every operation
	always_comb begin
		flags_out          = '0;
		flags_out[`FLAG_C] = carry;
		flags_out[`FLAG_S] = result[MSB];
		flags_out[`FLAG_O] = ovf;
		flags_out[`FLAG_Z] = (result == '0);
	end

	// zero flag against an operand compare
	always_comb begin
		if (opcode == `OP_SUB || opcode == `OP_CMP || opcode == `OP_XOR) begin
			assert final (flags_out[`FLAG_Z] == (op_a == op_b))
				else $error("alu zero flag disagrees with result %h", result);
		end
	end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  reg_sel_t rd_sel_a,
	input  reg_sel_t rd_sel_b,
	output data_t    rd_data_a,
	output data_t    rd_data_b,
	input  logic     we,
	input  logic     we_lo,
	input  logic     we_hi,
	input  reg_sel_t wr_sel,
	input  data_t    wr_data
);

	localparam int BYTE_W = `DATA_W / 2;

	data_t regs [`REG_NUM];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_sel] <= wr_data;
		end else begin
			// byte lanes for movl / movh
			if (we_lo) begin
				regs[wr_sel][BYTE_W-1:0] <= wr_data[BYTE_W-1:0];
			end
			if (we_hi) begin
				regs[wr_sel][`DATA_W-1:BYTE_W] <= wr_data[`DATA_W-1:BYTE_W];
			end
		end
	end

	// combinational reads
	assign rd_data_a = regs[rd_sel_a];
	assign rd_data_b = regs[rd_sel_b];

endmodule

/* instr_pointer.sv */
`timescale 1ns/1ps

module instr_pointer import core_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  restart,
	input  logic  advance,
	input  logic  jump,
	input  addr_t jump_addr,
	output addr_t instr_addr,
	output logic  half_sel
);

	addr_t word_addr;
	logic  half;

	always_ff @(posedge clk) begin
		if (!rst_n || restart) begin
			word_addr <= '0;
			half      <= 1'b0;
		end else if (jump) begin
			// jumps always land on the low half
			word_addr <= jump_addr;
			half      <= 1'b0;
		end else if (advance) begin
			if (half) begin
				word_addr <= word_addr + 1'b1;
			end
			half <= !half;
		end
	end

	assign instr_addr = word_addr;
	assign half_sel   = half;

	// control never asks for both in one save
	no_advance_and_jump: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(advance && jump)
	) else $error("instruction pointer got advance and jump together");

endmodule

/* core_control.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_control import core_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start,
	input  opcode_t opcode,
	input  logic    cond_pass,
	input  logic    alu_en,
	input  logic    mov_en,
	input  logic    movl_en,
	input  logic    movh_en,
	input  logic    movf_en,
	input  logic    jump_en,
	input  logic    load_en,
	input  logic    store_en,
	input  logic    halt_en,
	input  data_t   rd_data_a,
	input  data_t   rd_data_b,
	input  data_t   alu_result,
	input  flags_t  alu_flags,
	input  imm_t    imm,
	output flags_t  flags,
	output logic    rf_we,
	output logic    rf_we_lo,
	output logic    rf_we_hi,
	output data_t   wr_data,
	output logic    restart,
	output logic    advance,
	output logic    jump,
	output logic    mem_req,
	output logic    mem_wren,
	output addr_t   mem_addr,
	output data_t   mem_wdata,
	input  logic    mem_ack,
	input  data_t   mem_rdata,
	output logic    halted
);

	step_t step;
	data_t load_data;
	logic  save;
	logic  mem_op;

	assign save   = (step == STEP_SAVE);
	assign mem_op = (load_en || store_en) && cond_pass;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step     <= STEP_IDLE;
			flags    <= '0;
			mem_req  <= 1'b0;
			mem_wren <= 1'b0;
			halted   <= 1'b0;
		end else begin
			halted <= 1'b0;
			case (step)
				STEP_IDLE: if (start) step <= STEP_FETCH;
				STEP_FETCH: step <= STEP_DECODE;
				STEP_DECODE: step <= STEP_EXECUTE;
				STEP_EXECUTE: begin
					if (mem_op) begin
						mem_req  <= 1'b1;
						mem_wren <= store_en;
						step     <= STEP_MEM_REQ;
					end else begin
						step <= STEP_SAVE;
					end
				end
				// slow ack just stretches this step
				STEP_MEM_REQ: begin
					if (mem_ack) begin
						mem_req  <= 1'b0;
						mem_wren <= 1'b0;
						step     <= STEP_MEM_REL;
					end
				end
				STEP_MEM_REL: if (!mem_ack) step <= STEP_SAVE;
				STEP_SAVE: begin
					// cmp lands here too
					if (alu_en && cond_pass) flags <= alu_flags;
					if (halt_en && cond_pass) begin
						halted <= 1'b1;
						step   <= STEP_IDLE;
					end else begin
						step <= STEP_FETCH;
					end
				end
				default: step <= STEP_IDLE;
			endcase
		end
	end

	// address from rs, store data from rd
	always_ff @(posedge clk) begin
		if (step == STEP_EXECUTE) begin
			mem_addr  <= rd_data_b;
			mem_wdata <= rd_data_a;
		end
		if (step == STEP_MEM_REQ && mem_ack) begin
			load_data <= mem_rdata;
		end
	end

	// write-back source select
	always_comb begin
		rf_we    = 1'b0;
		rf_we_lo = 1'b0;
		rf_we_hi = 1'b0;
		wr_data  = alu_result;
		if (save && cond_pass) begin
			if (alu_en && opcode != `OP_CMP) begin
				rf_we = 1'b1;
			end else if (mov_en) begin
				rf_we   = 1'b1;
				wr_data = rd_data_b;
			end else if (movl_en) begin
				rf_we_lo = 1'b1;
				wr_data  = {8'h00, imm};
			end else if (movh_en) begin
				rf_we_hi = 1'b1;
				wr_data  = {imm, 8'h00};
			end else if (movf_en) begin
				rf_we   = 1'b1;
				wr_data = {{(`DATA_W-`FLAG_W){1'b0}}, flags};
			end else if (load_en) begin
				rf_we   = 1'b1;
				wr_data = load_data;
			end
		end
	end

	assign restart = (step == STEP_IDLE) && start;
	assign jump    = save && jump_en && cond_pass;
	assign advance = save && !jump;

	// four-phase rules
	req_held_until_ack: assert property (
		@(posedge clk) disable iff (!rst_n)
		(step == STEP_MEM_REQ && mem_req && !mem_ack) |=> mem_req
	) else $error("mem_req dropped before mem_ack");

	addr_stable_during_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_req |=> (!mem_req || $stable(mem_addr))
	) else $error("mem_addr changed while mem_req high");

endmodule

/* core_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_top import core_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	output logic   halted,
	output addr_t  instr_addr,
	input  instr_t instruction,
	output logic   mem_req,
	output logic   mem_wren,
	output addr_t  mem_addr,
	output data_t  mem_wdata,
	input  logic   mem_ack,
	input  data_t  mem_rdata
);

	half_t    instr;
	logic     half_sel;
	opcode_t  opcode;
	reg_sel_t rd;
	reg_sel_t rs;
	imm_t     imm;
	flags_t   flags;
	flags_t   alu_flags;
	data_t    rd_data_a;
	data_t    rd_data_b;
	data_t    alu_result;
	data_t    wr_data;
	logic     cond_pass;
	logic     alu_en;
	logic     mov_en;
	logic     movl_en;
	logic     movh_en;
	logic     movf_en;
	logic     jump_en;
	logic     load_en;
	logic     store_en;
	logic     halt_en;
	logic     rf_we;
	logic     rf_we_lo;
	logic     rf_we_hi;
	logic     restart;
	logic     advance;
	logic     jump;

	// low half runs first
	assign instr = half_sel ? instruction[`INSTR_W-1:`HALF_W] : instruction[`HALF_W-1:0];

	instr_decoder u_decoder (
		.instr(instr), .flags(flags), .opcode(opcode), .rd(rd), .rs(rs), .imm(imm),
		.cond_pass(cond_pass), .alu_en(alu_en), .mov_en(mov_en), .movl_en(movl_en),
		.movh_en(movh_en), .movf_en(movf_en), .jump_en(jump_en), .load_en(load_en),
		.store_en(store_en), .halt_en(halt_en)
	);

	alu u_alu (
		.opcode(opcode), .op_a(rd_data_a), .op_b(rd_data_b),
		.result(alu_result), .flags_out(alu_flags)
	);

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .rd_sel_a(rd), .rd_sel_b(rs),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .we(rf_we), .we_lo(rf_we_lo),
		.we_hi(rf_we_hi), .wr_sel(rd), .wr_data(wr_data)
	);

	// jump target comes from rs
	instr_pointer u_instr_pointer (
		.clk(clk), .rst_n(rst_n), .restart(restart), .advance(advance), .jump(jump),
		.jump_addr(rd_data_b), .instr_addr(instr_addr), .half_sel(half_sel)
	);

	core_control u_control (
		.clk(clk), .rst_n(rst_n), .start(start), .opcode(opcode), .cond_pass(cond_pass),
		.alu_en(alu_en), .mov_en(mov_en), .movl_en(movl_en), .movh_en(movh_en),
		.movf_en(movf_en), .jump_en(jump_en), .load_en(load_en), .store_en(store_en),
		.halt_en(halt_en), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.alu_result(alu_result), .alu_flags(alu_flags), .imm(imm), .flags(flags),
		.rf_we(rf_we), .rf_we_lo(rf_we_lo), .rf_we_hi(rf_we_hi), .wr_data(wr_data),
		.restart(restart), .advance(advance), .jump(jump), .mem_req(mem_req),
		.mem_wren(mem_wren), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata), .halted(halted)
	);

endmodule

/* tb_core.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core import core_pkg::*; ();

	logic   clk;
	logic   rst_n;
	logic   start;
	logic   halted;
	addr_t  instr_addr;
	instr_t instruction;
	logic   mem_req;
	logic   mem_wren;
	addr_t  mem_addr;
	data_t  mem_wdata;
	logic   mem_ack;
	data_t  mem_rdata;

	logic [31:0] tests_mem [0:255];
	instr_t      prog [0:255];
	int          prog_len;
	data_t       dmem [addr_t];
	addr_t       exp_addr [$];
	data_t       exp_data [$];
	int          file_pos;
	int          error_count = 0;
	int          check_count = 0;
	int          halt_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	core_top u_dut (
		.clk(clk), .rst_n(rst_n), .start(start), .halted(halted),
		.instr_addr(instr_addr), .instruction(instruction),
		.mem_req(mem_req), .mem_wren(mem_wren), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// past the program the rom returns an address-based pattern
	function automatic instr_t rom_word(input addr_t addr);
		if (addr < prog_len) begin
			return prog[addr];
		end
		return {~addr, addr};
	endfunction

	function automatic data_t mem_read(input addr_t addr);
		if (dmem.exists(addr)) begin
			return dmem[addr];
		end
		return {addr[7:0], addr[15:8]} ^ 16'h5a5a;
	endfunction

	// run length bound from halves per run plus handshakes
	function automatic int compute_cycle_limit();
		int pos;
		int t;
		int i;
		int instrs;
		int accesses;
		logic [31:0] word;
		pos      = 1;
		instrs   = 0;
		accesses = 0;
		for (t = 0; t < int'(tests_mem[0]); t++) begin
			for (i = 0; i < int'(tests_mem[pos]); i++) begin
				word = tests_mem[pos + 4 + i];
				if (word[15:12] == `OP_LOAD || word[15:12] == `OP_STORE) begin
					accesses += tests_mem[pos + 3];
				end
				if (word[31:28] == `OP_LOAD || word[31:28] == `OP_STORE) begin
					accesses += tests_mem[pos + 3];
				end
			end
			instrs += 2 * tests_mem[pos] * tests_mem[pos + 3];
			pos += 4 + tests_mem[pos] + tests_mem[pos + 1] + tests_mem[pos + 2];
		end
		return 40 * instrs + 10 * accesses + 100;
	endfunction

	task automatic check_store(input addr_t addr, input data_t data);
		check_count++;
		if (exp_addr.size() == 0) begin
			error_count++;
			$display("store of %h to address %h was not expected", data, addr);
		end else begin
			if (addr !== exp_addr[0] || data !== exp_data[0]) begin
				error_count++;
				$display("[ERROR] %0t: store %h to %h, expected %h to %h",
					$time, data, addr, exp_data[0], exp_addr[0]);
			end
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
		end
		dmem[addr] = data;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic run_test(input int test_idx);
		int n_words;
		int n_pre;
		int n_stores;
		int n_starts;
		int i;
		int halts_before;
		n_words  = tests_mem[file_pos];
		n_pre    = tests_mem[file_pos + 1];
		n_stores = tests_mem[file_pos + 2];
		n_starts = tests_mem[file_pos + 3];
		file_pos += 4;
		prog_len = n_words;
		for (i = 0; i < n_words; i++) begin
			prog[i] = tests_mem[file_pos + i];
		end
		file_pos += n_words;
		dmem.delete();
		for (i = 0; i < n_pre; i++) begin
			dmem[tests_mem[file_pos + i][31:16]] = tests_mem[file_pos + i][15:0];
		end
		file_pos += n_pre;
		for (i = 0; i < n_stores; i++) begin
			exp_addr.push_back(tests_mem[file_pos + i][31:16]);
			exp_data.push_back(tests_mem[file_pos + i][15:0]);
		end
		file_pos += n_stores;
		apply_reset();
		// idle core must stay off the data bus
		repeat (4) begin
			@(negedge clk);
			check_count++;
			if (mem_req !== 1'b0 || halted !== 1'b0) begin
				error_count++;
				$display("[ERROR] %0t: test %0d idle core drives mem_req=%b halted=%b",
					$time, test_idx, mem_req, halted);
			end
		end
		for (i = 0; i < n_starts; i++) begin
			halts_before = halt_count;
			pulse_start();
			while (halt_count == halts_before) @(negedge clk);
			repeat (3) @(negedge clk);
			check_count++;
			if (halt_count != halts_before + 1) begin
				error_count++;
				$display("test %0d: halted pulsed %0d times for one start",
					test_idx, halt_count - halts_before);
			end
		end
		check_count++;
		if (exp_addr.size() != 0) begin
			error_count++;
			$display("test %0d: %0d expected stores never happened", test_idx, exp_addr.size());
			exp_addr.delete();
			exp_data.delete();
		end
	endtask

	always @(negedge clk) begin
		instruction <= rom_word(instr_addr);
	end

	// one count per halted pulse
	always @(posedge clk) begin
		if (halted) halt_count <= halt_count + 1;
	end

	// data memory with four-phase req/ack and random ack delay
	initial begin : data_memory
		int delay;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		void'($urandom(32'h5c52ecf6));
		forever begin
			@(negedge clk);
			if (mem_req) begin
				delay = $urandom % 6;
				repeat (delay) @(negedge clk);
				if (mem_wren) begin
					check_store(mem_addr, mem_wdata);
				end else begin
					mem_rdata = mem_read(mem_addr);
				end
				mem_ack = 1'b1;
				while (mem_req) @(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : watchdog
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_count);
		$display("Something failed");
		$finish;
	end

	initial begin : main
		int n_tests;
		int t;
		rst_n       = 1'b0;
		start       = 1'b0;
		instruction = '0;
		$readmemh("core_tests.txt", tests_mem);
		cycle_limit = compute_cycle_limit();
		n_tests     = tests_mem[0];
		file_pos    = 1;
		if (n_tests <= 0) begin
			error_count++;
			$display("no tests could be read from core_tests.txt");
		end
		for (t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		repeat (2) @(negedge clk);
		$display("tb_core done: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* core_tests.txt */
// per test: word count, preload count, store count, start count, then program words
// (low half runs first), preloads as {addr, value}, expected stores as {addr, data}
00000005
// byte lanes of movl and movh
00000005 00000000 00000002 00000001
82247268 B2807480 779A8756 B7007882 D000F000
00401234 0041ABCD
// alu results, then cmp flags read back by movf
00000010 00000000 00000008 00000001
82FE73E0 8402744A 66407F00 B7C00680
16806640 6640B7C0 B7C02680 36806640
6640B7C0 B7C04680 CA005440 6840BBC0
58800880 BBC0CA00 CA005480 F000BBC0
00808115 00807ECB 00800120 00807FF5
00807ED5 00800003 00800004 00800008
// loads and stores through the handshake
00000006 00000002 00000003 00000001
74227220 A880A640 7C400700 0700B780 AB80B780 F000BA40
00101234 00110F0F
00202143 00203052 00103052
// conditional jumps and a failed-condition mov
00000009 00000000 00000003 00000001
740A720A 7C087E60 528076EE B3C09190 66609160
7412B7C0 91905280 6660B5C0 F000B7C0
00300077 00300009 00300005
// halt, then restart with registers kept
00000003 00000000 00000002 00000002
7EA07406 B3C00280 D000F000
00500003 00500006

/* src.f */
+incdir+.
core_pkg.sv
instr_decoder.sv
alu.sv
reg_file.sv
instr_pointer.sv
core_control.sv
core_top.sv
tb_core.sv

/* Bender.yml */
package:
  name: core_top

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - instr_decoder.sv
      - alu.sv
      - reg_file.sv
      - instr_pointer.sv
      - core_control.sv
      - core_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_core.sv
